// File: rtl/bridge_cfg.svh
//////////////////////////////////////////////////////////////////////
// Bridge build settings. Queue depth and credit count must be powers of
// two; the AXI4 byte address is BRIDGE_ADDR_W plus two bits wide.
//////////////////////////////////////////////////////////////////////

`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// data word width in bits.
`define BRIDGE_DATA_W 32

// PI1 word-address width.
`define BRIDGE_ADDR_W 10

// request queue entries.
`define BRIDGE_QUEUE_DEPTH 4

// command slots held by the bridge, also the initial credit count.
`define BRIDGE_CREDITS 2

// on-chip memory size in words.
`define BRIDGE_MEM_WORDS 1024

`endif

// File: rtl/pi1_pkg.sv
//////////////////////////////////////////////////////////////////////
// PI1 request and response types. NOOP never reaches the bridge.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "bridge_cfg.svh"

package pi1_pkg;

	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RW   = 2'b11 // read the old word, then write the new one.
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t                     op;
		logic [`BRIDGE_ADDR_W-1:0]   addr;
		logic [`BRIDGE_DATA_W-1:0]   data;
		logic [`BRIDGE_DATA_W/8-1:0] sel;
	} pi1_req_t;

	typedef struct packed {
		logic [`BRIDGE_DATA_W-1:0] data;
		logic                      wr_only; // set when the request was a plain write.
	} pi1_rsp_t;

endpackage

`default_nettype wire

// File: rtl/axi4_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4 encodings for a single-beat link with ID, lock, cache, prot and
// qos all tied to zero.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "bridge_cfg.svh"

package axi4_pkg;

	typedef enum logic [1:0] {
		AXI4_OKAY   = 2'b00,
		AXI4_EXOKAY = 2'b01,
		AXI4_SLVERR = 2'b10,
		AXI4_DECERR = 2'b11
	} axi4_resp_t;

	typedef enum logic [1:0] {
		AXI4_FIXED = 2'b00,
		AXI4_INCR  = 2'b01,
		AXI4_WRAP  = 2'b10
	} axi4_burst_t;

	// log2 of the bytes in one data word.
	localparam logic [2:0] AXI4_SIZE_WORD = 3'($clog2(`BRIDGE_DATA_W / 8));

	typedef struct packed {
		logic       lock;
		logic [3:0] cache;
		logic [2:0] prot;
		logic [3:0] qos;
	} axi4_attr_t;

endpackage

`default_nettype wire

// File: rtl/pi1_cmd_if.sv
//////////////////////////////////////////////////////////////////////
// Queue to bridge command link. There is no ready; the sender spends one
// credit per command and the receiver returns it with credit_ret.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

interface pi1_cmd_if import pi1_pkg::*; ();

	logic     cmd_valid; // one cycle per transferred command.
	pi1_req_t cmd;
	logic     credit_ret; // one cycle per freed command slot.

	modport src (
		output cmd_valid,
		output cmd,
		input  credit_ret
	);

	modport dst (
		input  cmd_valid,
		input  cmd,
		output credit_ret
	);

endinterface

`default_nettype wire

// File: rtl/pi1_req_queue.sv
//////////////////////////////////////////////////////////////////////
// Synchronous request FIFO. Requests must arrive already qualified as
// non-NOOP; a command is sent only while a credit is held.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module pi1_req_queue import pi1_pkg::*; (
	input  wire           axi4_clk_i,
	input  wire           rst_n_i,
	input  wire           req_valid_i,
	input  wire pi1_req_t req_i,
	output logic          rdy_o,
	pi1_cmd_if.src        cmd
);

	localparam int DEPTH = `BRIDGE_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(`BRIDGE_CREDITS + 1);

	pi1_req_t         fifo_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             push;
	logic             pop;

	assign rdy_o = (count != CNT_W'(DEPTH));
	assign push  = req_valid_i && rdy_o;

	// every cycle with an entry and a credit is a transfer.
	assign pop = (count != '0) && (credits != '0);

	assign cmd.cmd_valid = pop;
	assign cmd.cmd       = fifo_mem[rd_ptr];

	always_ff @(posedge axi4_clk_i) begin
		if (push) begin
			fifo_mem[wr_ptr] <= req_i;
		end
	end

	always_ff @(posedge axi4_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= CRD_W'(`BRIDGE_CREDITS);
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps since the depth is a power of two.
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count   <= count + CNT_W'(push) - CNT_W'(pop);
			credits <= credits + CRD_W'(cmd.credit_ret) - CRD_W'(pop);
		end
	end

endmodule

`default_nettype wire

// File: rtl/pi1q_to_axi4.sv
//////////////////////////////////////////////////////////////////////
// PI1 command to single-beat AXI4 bridge, one transaction in flight.
// Swap reads first, then writes the same address; B status fills write data.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module pi1q_to_axi4 import pi1_pkg::*; (
	input  wire                         axi4_clk_i,
	input  wire                         rst_n_i,
	pi1_cmd_if.dst                      cmd,
	output logic                        rsp_valid_o,
	output pi1_rsp_t                    rsp_o,
	output logic [`BRIDGE_ADDR_W+1:0]   axi4_awaddr_o,
	output logic                        axi4_awvalid_o,
	input  wire                         axi4_awready_i,
	output logic [`BRIDGE_DATA_W-1:0]   axi4_wdata_o,
	output logic [`BRIDGE_DATA_W/8-1:0] axi4_wstrb_o,
	output logic                        axi4_wvalid_o,
	input  wire                         axi4_wready_i,
	output logic                        axi4_bready_o,
	input  wire [1:0]                   axi4_bresp_i,
	input  wire                         axi4_bvalid_i,
	output logic [`BRIDGE_ADDR_W+1:0]   axi4_araddr_o,
	output logic                        axi4_arvalid_o,
	input  wire                         axi4_arready_i,
	output logic                        axi4_rready_o,
	input  wire [`BRIDGE_DATA_W-1:0]    axi4_rdata_i,
	input  wire                         axi4_rvalid_i
);

	localparam int DATA_W = `BRIDGE_DATA_W;
	localparam int SEL_W  = DATA_W / 8;
	localparam int OFS_W  = $clog2(SEL_W);
	localparam int SLOTS  = `BRIDGE_CREDITS;
	localparam int SLOT_W = $clog2(SLOTS);
	localparam int SCNT_W = $clog2(SLOTS + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR,
		ST_RD_WAIT,
		ST_WR_WAIT,
		ST_SWAP_WR
	} state_t;

	state_t                    state;
	pi1_req_t                  slot_mem [SLOTS];
	logic [SLOT_W-1:0]         slot_wr;
	logic [SLOT_W-1:0]         slot_rd;
	logic [SCNT_W-1:0]         slot_cnt;
	pi1_req_t                  head;
	logic                      start;
	logic                      done;
	logic                      wr_accepted;
	pi1_op_t                   op_q;
	logic [`BRIDGE_ADDR_W+1:0] ax_addr;
	logic [DATA_W-1:0]         rdata_hold;

	// byte offset of the lowest selected byte.
	function automatic logic [OFS_W-1:0] low_sel_idx(input logic [SEL_W-1:0] sel);
		logic [OFS_W-1:0] idx;
		idx = '0;
		for (int i = SEL_W - 1; i >= 0; i--) begin
			if (sel[i]) begin
				idx = OFS_W'(i);
			end
		end
		return idx;
	endfunction

	// a command arriving into an empty buffer starts at once.
	assign head  = (slot_cnt != '0) ? slot_mem[slot_rd] : cmd.cmd;
	assign start = (state == ST_IDLE) && ((slot_cnt != '0) || cmd.cmd_valid);

	assign wr_accepted = (!axi4_awvalid_o || axi4_awready_i) &&
		(!axi4_wvalid_o || axi4_wready_i);

	assign done = ((state == ST_RD_WAIT) && axi4_rvalid_i && axi4_rready_o &&
		(op_q != PI1_RW)) ||
		((state == ST_WR_WAIT) && axi4_bvalid_i && axi4_bready_o);

	assign axi4_awaddr_o = ax_addr;
	assign axi4_araddr_o = ax_addr;

	always_ff @(posedge axi4_clk_i) begin
		if (cmd.cmd_valid) begin
			slot_mem[slot_wr] <= cmd.cmd;
		end
		if (start) begin
			op_q         <= head.op;
			ax_addr      <= {head.addr, low_sel_idx(head.sel)};
			axi4_wdata_o <= head.data;
			axi4_wstrb_o <= head.sel;
		end
		if ((state == ST_RD_WAIT) && axi4_rvalid_i) begin
			rdata_hold <= axi4_rdata_i;
		end
		if (done) begin
			rsp_o.wr_only <= (op_q == PI1_WR);
			if (state == ST_RD_WAIT) begin
				rsp_o.data <= axi4_rdata_i;
			end else if (op_q == PI1_RW) begin
				rsp_o.data <= rdata_hold; // swap returns the old word.
			end else begin
				rsp_o.data <= DATA_W'(axi4_bresp_i);
			end
		end
	end

	always_ff @(posedge axi4_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state          <= ST_IDLE;
			slot_wr        <= '0;
			slot_rd        <= '0;
			slot_cnt       <= '0;
			axi4_awvalid_o <= 1'b0;
			axi4_wvalid_o  <= 1'b0;
			axi4_bready_o  <= 1'b0;
			axi4_arvalid_o <= 1'b0;
			axi4_rready_o  <= 1'b0;
			rsp_valid_o    <= 1'b0;
			cmd.credit_ret <= 1'b0;
		end else begin
			rsp_valid_o    <= done;
			cmd.credit_ret <= done; // the slot is freed with the response.
			if (cmd.cmd_valid) begin
				slot_wr <= slot_wr + 1'b1;
			end
			if (done) begin
				slot_rd <= slot_rd + 1'b1;
			end
			slot_cnt <= slot_cnt + SCNT_W'(cmd.cmd_valid) - SCNT_W'(done);
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_ADDR;
						if (head.op == PI1_WR) begin
							axi4_awvalid_o <= 1'b1;
							axi4_wvalid_o  <= 1'b1;
						end else begin
							axi4_arvalid_o <= 1'b1;
						end
					end
				end
				ST_ADDR, ST_SWAP_WR: begin
					if (axi4_arvalid_o) begin
						if (axi4_arready_i) begin
							axi4_arvalid_o <= 1'b0;
							axi4_rready_o  <= 1'b1;
							state          <= ST_RD_WAIT;
						end
					end else begin
						if (axi4_awready_i) begin
							axi4_awvalid_o <= 1'b0;
						end
						if (axi4_wready_i) begin
							axi4_wvalid_o <= 1'b0;
						end
						if (wr_accepted) begin
							axi4_bready_o <= 1'b1;
							state         <= ST_WR_WAIT;
						end
					end
				end
				ST_RD_WAIT: begin
					if (axi4_rvalid_i) begin
						axi4_rready_o <= 1'b0;
						if (op_q == PI1_RW) begin
							axi4_awvalid_o <= 1'b1;
							axi4_wvalid_o  <= 1'b1;
							state          <= ST_SWAP_WR;
						end else begin
							state <= ST_IDLE;
						end
					end
				end
				ST_WR_WAIT: begin
					if (axi4_bvalid_i) begin
						axi4_bready_o <= 1'b0;
						state         <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/axi4_sram.sv
//////////////////////////////////////////////////////////////////////
// Single-beat AXI4 slave memory. Addresses wrap at BRIDGE_MEM_WORDS and
// every response is OKAY; one write and one read outstanding at most.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module axi4_sram import axi4_pkg::*; (
	input  wire                         axi4_clk_i,
	input  wire                         rst_n_i,
	input  wire [`BRIDGE_ADDR_W+1:0]    axi4_awaddr_i,
	input  wire                         axi4_awvalid_i,
	output logic                        axi4_awready_o,
	input  wire [`BRIDGE_DATA_W-1:0]    axi4_wdata_i,
	input  wire [`BRIDGE_DATA_W/8-1:0]  axi4_wstrb_i,
	input  wire                         axi4_wvalid_i,
	output logic                        axi4_wready_o,
	input  wire                         axi4_bready_i,
	output axi4_resp_t                  axi4_bresp_o,
	output logic                        axi4_bvalid_o,
	input  wire [`BRIDGE_ADDR_W+1:0]    axi4_araddr_i,
	input  wire                         axi4_arvalid_i,
	output logic                        axi4_arready_o,
	input  wire                         axi4_rready_i,
	output logic [`BRIDGE_DATA_W-1:0]   axi4_rdata_o,
	output logic                        axi4_rvalid_o
);

	localparam int DATA_W = `BRIDGE_DATA_W;
	localparam int SEL_W  = DATA_W / 8;
	localparam int WORDS  = `BRIDGE_MEM_WORDS;
	localparam int IDX_W  = $clog2(WORDS);

	logic [DATA_W-1:0] mem [WORDS];
	logic              wr_fire;
	logic              rd_fire;
	logic [IDX_W-1:0]  wr_idx;
	logic [IDX_W-1:0]  rd_idx;

	// AW and W are taken together, and only once B has been handed over.
	assign wr_fire        = axi4_awvalid_i && axi4_wvalid_i && !axi4_bvalid_o;
	assign axi4_awready_o = wr_fire;
	assign axi4_wready_o  = wr_fire;

	assign rd_fire        = axi4_arvalid_i && !axi4_rvalid_o;
	assign axi4_arready_o = rd_fire;

	assign wr_idx = IDX_W'(axi4_awaddr_i >> AXI4_SIZE_WORD);
	assign rd_idx = IDX_W'(axi4_araddr_i >> AXI4_SIZE_WORD);

	assign axi4_bresp_o = AXI4_OKAY;

	always_ff @(posedge axi4_clk_i) begin
		if (wr_fire) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (axi4_wstrb_i[b]) begin
					mem[wr_idx][8*b +: 8] <= axi4_wdata_i[8*b +: 8];
				end
			end
		end
		if (rd_fire) begin
			axi4_rdata_o <= mem[rd_idx];
		end
	end

	always_ff @(posedge axi4_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			axi4_bvalid_o <= 1'b0;
			axi4_rvalid_o <= 1'b0;
		end else begin
			if (wr_fire) begin
				axi4_bvalid_o <= 1'b1;
			end else if (axi4_bready_i) begin
				axi4_bvalid_o <= 1'b0;
			end
			if (rd_fire) begin
				axi4_rvalid_o <= 1'b1;
			end else if (axi4_rready_i) begin
				axi4_rvalid_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/pi1_axi4_top.sv
//////////////////////////////////////////////////////////////////////
// PI1 port over a request queue and AXI4 bridge into on-chip memory.
// A write responds with zero; the AXI4 link is internal.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module pi1_axi4_top import pi1_pkg::*, axi4_pkg::*; (
	input  wire                         axi4_clk_i,
	input  wire                         rst_n_i,
	input  wire [1:0]                   pi1_op_i,
	input  wire [`BRIDGE_ADDR_W-1:0]    pi1_addr_i,
	input  wire [`BRIDGE_DATA_W-1:0]    pi1_data_i,
	input  wire [`BRIDGE_DATA_W/8-1:0]  pi1_sel_i,
	output logic                        pi1_rdy_o,
	output logic                        pi1_rsp_valid_o,
	output logic [`BRIDGE_DATA_W-1:0]   pi1_data_o
);

	pi1_req_t                    req;
	logic                        req_valid;
	pi1_rsp_t                    rsp;
	logic [`BRIDGE_ADDR_W+1:0]   awaddr;
	logic                        awvalid;
	logic                        awready;
	logic [`BRIDGE_DATA_W-1:0]   wdata;
	logic [`BRIDGE_DATA_W/8-1:0] wstrb;
	logic                        wvalid;
	logic                        wready;
	logic                        bready;
	axi4_resp_t                  bresp;
	logic                        bvalid;
	logic [`BRIDGE_ADDR_W+1:0]   araddr;
	logic                        arvalid;
	logic                        arready;
	logic                        rready;
	logic [`BRIDGE_DATA_W-1:0]   rdata;
	logic                        rvalid;

	pi1_cmd_if cmd_if ();

	assign req = '{
		op:   pi1_op_t'(pi1_op_i),
		addr: pi1_addr_i,
		data: pi1_data_i,
		sel:  pi1_sel_i
	};
	assign req_valid = (pi1_op_i != PI1_NOOP);

	// the bridge reports write status in the data word, PI1 expects zero.
	assign pi1_data_o = rsp.wr_only ? '0 : rsp.data;

	pi1_req_queue u_queue (
		.axi4_clk_i  (axi4_clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid),
		.req_i       (req),
		.rdy_o       (pi1_rdy_o),
		.cmd         (cmd_if.src)
	);

	pi1q_to_axi4 u_bridge (
		.axi4_clk_i     (axi4_clk_i),
		.rst_n_i        (rst_n_i),
		.cmd            (cmd_if.dst),
		.rsp_valid_o    (pi1_rsp_valid_o),
		.rsp_o          (rsp),
		.axi4_awaddr_o  (awaddr),
		.axi4_awvalid_o (awvalid),
		.axi4_awready_i (awready),
		.axi4_wdata_o   (wdata),
		.axi4_wstrb_o   (wstrb),
		.axi4_wvalid_o  (wvalid),
		.axi4_wready_i  (wready),
		.axi4_bready_o  (bready),
		.axi4_bresp_i   (bresp),
		.axi4_bvalid_i  (bvalid),
		.axi4_araddr_o  (araddr),
		.axi4_arvalid_o (arvalid),
		.axi4_arready_i (arready),
		.axi4_rready_o  (rready),
		.axi4_rdata_i   (rdata),
		.axi4_rvalid_i  (rvalid)
	);

	axi4_sram u_sram (
		.axi4_clk_i     (axi4_clk_i),
		.rst_n_i        (rst_n_i),
		.axi4_awaddr_i  (awaddr),
		.axi4_awvalid_i (awvalid),
		.axi4_awready_o (awready),
		.axi4_wdata_i   (wdata),
		.axi4_wstrb_i   (wstrb),
		.axi4_wvalid_i  (wvalid),
		.axi4_wready_o  (wready),
		.axi4_bready_i  (bready),
		.axi4_bresp_o   (bresp),
		.axi4_bvalid_o  (bvalid),
		.axi4_araddr_i  (araddr),
		.axi4_arvalid_i (arvalid),
		.axi4_arready_o (arready),
		.axi4_rready_i  (rready),
		.axi4_rdata_o   (rdata),
		.axi4_rvalid_o  (rvalid)
	);

endmodule

`default_nettype wire

// File: bench/pi1_axi4_props.sv
//////////////////////////////////////////////////////////////////////
// Bound into every pi1q_to_axi4. Assumes one clock and async low reset.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module pi1_axi4_props (
	input wire                       clk_i,
	input wire                       rst_n_i,
	input wire                       cmd_valid_i,
	input wire                       credit_ret_i,
	input wire                       rsp_valid_i,
	input wire                       awvalid_i,
	input wire                       awready_i,
	input wire [`BRIDGE_ADDR_W+1:0]  awaddr_i,
	input wire                       wvalid_i,
	input wire                       wready_i,
	input wire [`BRIDGE_DATA_W-1:0]  wdata_i,
	input wire [`BRIDGE_DATA_W/8-1:0] wstrb_i,
	input wire                       arvalid_i,
	input wire                       arready_i,
	input wire [`BRIDGE_ADDR_W+1:0]  araddr_i,
	input wire                       bready_i
);

	int outstanding; // commands taken by the bridge and not yet answered.

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(cmd_valid_i) - int'(credit_ret_i);
		end
	end

	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
		else $error("AWVALID dropped or AWADDR changed before AWREADY");

	w_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
		else $error("WVALID dropped or write data changed before WREADY");

	ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
		else $error("ARVALID dropped or ARADDR changed before ARREADY");

	credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		outstanding <= `BRIDGE_CREDITS && (credit_ret_i -> outstanding > 0))
		else $error("credit returned with no command slot in use");

	rsp_after_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rsp_valid_i |-> outstanding > 0)
		else $error("response issued without an earlier command");

	ar_not_in_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		arvalid_i |-> !bready_i)
		else $error("ARVALID raised while a write response is awaited");

endmodule

bind pi1q_to_axi4 pi1_axi4_props u_props (
	.clk_i        (axi4_clk_i),
	.rst_n_i      (rst_n_i),
	.cmd_valid_i  (cmd.cmd_valid),
	.credit_ret_i (cmd.credit_ret),
	.rsp_valid_i  (rsp_valid_o),
	.awvalid_i    (axi4_awvalid_o),
	.awready_i    (axi4_awready_i),
	.awaddr_i     (axi4_awaddr_o),
	.wvalid_i     (axi4_wvalid_o),
	.wready_i     (axi4_wready_i),
	.wdata_i      (axi4_wdata_o),
	.wstrb_i      (axi4_wstrb_o),
	.arvalid_i    (axi4_arvalid_o),
	.arready_i    (axi4_arready_i),
	.araddr_i     (axi4_araddr_o),
	.bready_i     (axi4_bready_o)
);

`default_nettype wire

// File: bench/tb_pi1_axi4.sv
//////////////////////////////////////////////////////////////////////
// Reads its requests from bench/pi1_axi4_stimulus.txt, run from the
// project root. A word must be written before the file reads it.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bridge_cfg.svh"

module tb_pi1_axi4 import pi1_pkg::*; ();

	localparam int    DATA_W    = `BRIDGE_DATA_W;
	localparam int    ADDR_W    = `BRIDGE_ADDR_W;
	localparam int    SEL_W     = DATA_W / 8;
	localparam int    MAX_REQ   = 64;
	localparam string STIM_FILE = "bench/pi1_axi4_stimulus.txt";

	logic              axi4_clk = 1'b0;
	logic              rst_n;
	logic [1:0]        pi1_op;
	logic [ADDR_W-1:0] pi1_addr;
	logic [DATA_W-1:0] pi1_data;
	logic [SEL_W-1:0]  pi1_sel;
	logic              pi1_rdy;
	logic              pi1_rsp_valid;
	logic [DATA_W-1:0] pi1_rdata;

	logic [1:0]        stim_op   [MAX_REQ];
	logic [ADDR_W-1:0] stim_addr [MAX_REQ];
	logic [DATA_W-1:0] stim_data [MAX_REQ];
	logic [SEL_W-1:0]  stim_sel  [MAX_REQ];
	int                stim_gap  [MAX_REQ];
	logic [DATA_W-1:0] stim_exp  [MAX_REQ];
	logic [DATA_W-1:0] ref_mem   [`BRIDGE_MEM_WORDS];

	logic [DATA_W-1:0] exp_q[$];
	string             name_q[$];
	int                n_req = 0;
	int                exp_total = 0;
	int                rsp_count = 0;
	int                stall_cycles = 0;
	int                checks = 0;
	int                errors = 0;
	logic              loaded = 1'b0;
	logic              verdict_done = 1'b0;

	pi1_axi4_top uut (
		.axi4_clk_i      (axi4_clk),
		.rst_n_i         (rst_n),
		.pi1_op_i        (pi1_op),
		.pi1_addr_i      (pi1_addr),
		.pi1_data_i      (pi1_data),
		.pi1_sel_i       (pi1_sel),
		.pi1_rdy_o       (pi1_rdy),
		.pi1_rsp_valid_o (pi1_rsp_valid),
		.pi1_data_o      (pi1_rdata)
	);

	always #20 axi4_clk = ~axi4_clk;

	task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	function automatic string op_name(input logic [1:0] op);
		case (op)
			PI1_WR:  return "wr";
			PI1_RD:  return "rd";
			PI1_RW:  return "rw";
			default: return "noop";
		endcase
	endfunction

	task automatic load_stimulus();
		int                fd;
		int                code;
		int                line_no;
		string             line;
		logic [1:0]        op_v;
		logic [ADDR_W-1:0] addr_v;
		logic [DATA_W-1:0] data_v;
		logic [SEL_W-1:0]  sel_v;
		int                gap_v;
		logic [DATA_W-1:0] exp_v;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("error: cannot open the stimulus file %s", STIM_FILE);
			errors++;
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				line_no++;
				if (code > 0 && line.len() > 1 && line[0] != "#") begin
					code = $sscanf(line, "%h %h %h %h %d %h",
						op_v, addr_v, data_v, sel_v, gap_v, exp_v);
					if (code != 6) begin
						$display("error: stimulus line %0d does not have six fields", line_no);
						errors++;
					end else if (n_req == MAX_REQ) begin
						$display("error: more than %0d requests in the stimulus file", MAX_REQ);
						errors++;
					end else begin
						stim_op[n_req]   = op_v;
						stim_addr[n_req] = addr_v;
						stim_data[n_req] = data_v;
						stim_sel[n_req]  = sel_v;
						stim_gap[n_req]  = gap_v;
						stim_exp[n_req]  = exp_v;
						if (op_v != PI1_NOOP) begin
							exp_total++;
						end
						n_req++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// byte-strobed reference memory that also gives the response word.
	task automatic model_access(input logic [1:0] op, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, input logic [SEL_W-1:0] sel,
		output logic [DATA_W-1:0] result);
		logic [DATA_W-1:0] old_word;
		logic [DATA_W-1:0] new_word;
		old_word = ref_mem[addr];
		new_word = old_word;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				new_word[8*b +: 8] = data[8*b +: 8];
			end
		end
		result = (op == PI1_WR) ? '0 : old_word;
		if (op != PI1_RD) begin
			ref_mem[addr] = new_word;
		end
	endtask

	// called 2 ns after a rising edge; returns at the same phase.
	task automatic apply_request(input int i);
		logic              accepted;
		logic [DATA_W-1:0] model_word;
		accepted = 1'b0;
		pi1_op   = stim_op[i];
		pi1_addr = stim_addr[i];
		pi1_data = stim_data[i];
		pi1_sel  = stim_sel[i];
		while (!accepted) begin
			@(negedge axi4_clk);
			accepted = pi1_rdy;
			if (!accepted && stim_op[i] != PI1_NOOP) begin
				stall_cycles++;
			end
			@(posedge axi4_clk);
			#2;
		end
		if (stim_op[i] != PI1_NOOP) begin
			model_access(stim_op[i], stim_addr[i], stim_data[i], stim_sel[i], model_word);
			check_value($sformatf("model_req%0d", i), stim_exp[i], model_word);
			exp_q.push_back(stim_exp[i]);
			name_q.push_back($sformatf("rsp_req%0d_%s", i, op_name(stim_op[i])));
		end
		pi1_op = PI1_NOOP;
		repeat (stim_gap[i]) begin
			@(posedge axi4_clk);
			#2;
		end
	endtask

	// responses are checked mid-cycle, where they are stable.
	always @(negedge axi4_clk) begin
		if (rst_n && pi1_rsp_valid) begin
			if (exp_q.size() == 0) begin
				$display("error: a response arrived with no request pending at %0t", $time);
				errors++;
			end else begin
				check_value(name_q.pop_front(), exp_q.pop_front(), pi1_rdata);
			end
			rsp_count++;
		end
	end

	initial begin
		wait (loaded);
		repeat (n_req * 40 + 200) @(posedge axi4_clk);
		$display("error: timeout, responses stopped arriving (%0d of %0d received)",
			rsp_count, exp_total);
		verdict_done = 1'b1;
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst_n    = 1'b0;
		pi1_op   = PI1_NOOP;
		pi1_addr = '0;
		pi1_data = '0;
		pi1_sel  = '0;
		load_stimulus();
		loaded = 1'b1;
		repeat (8) @(posedge axi4_clk);
		#2;
		rst_n = 1'b1;
		@(negedge axi4_clk);
		check_value("rdy_after_reset", DATA_W'(1), DATA_W'(pi1_rdy));
		check_value("rsp_valid_after_reset", '0, DATA_W'(pi1_rsp_valid));
		@(posedge axi4_clk);
		#2;
		if (n_req == 0) begin
			$display("error: the stimulus file held no requests");
			errors++;
		end else begin
			for (int i = 0; i < n_req; i++) begin
				apply_request(i);
			end
			wait (rsp_count >= exp_total);
			repeat (10) @(posedge axi4_clk); // room for a stray response.
			check_value("backpressure_seen", DATA_W'(1), DATA_W'(stall_cycles != 0));
		end
		check_value("response_count", DATA_W'(exp_total), DATA_W'(rsp_count));
		$display("checks %0d, errors %0d, stall cycles %0d", checks, errors, stall_cycles);
		verdict_done = 1'b1;
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// reached only when the simulator stops the run before a verdict.
	final begin
		if (!verdict_done) begin
			$display("error: the run stopped early, checks %0d, errors %0d", checks, errors);
			$display("TEST FAILED");
		end
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/pi1_pkg.sv
rtl/axi4_pkg.sv
rtl/pi1_cmd_if.sv
rtl/pi1_req_queue.sv
rtl/pi1q_to_axi4.sv
rtl/axi4_sram.sv
rtl/pi1_axi4_top.sv
bench/pi1_axi4_props.sv
bench/tb_pi1_axi4.sv

// File: Makefile
# Verilator flow for the PI1 to AXI4 bridge testbench.
# Run make from the project root so the stimulus file path resolves.

TOP = tb_pi1_axi4

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// File: bench/pi1_axi4_stimulus.txt
# columns: op addr data sel gap expected, all hex except gap (idle cycles, decimal)
# op: 0 noop, 1 write, 2 read, 3 swap; expected is the response word
# idle noop first, it must not produce a response
0 000 00000000 0 6 00000000
1 010 12345678 f 3 00000000
2 010 00000000 f 4 12345678
# byte and half-word selects merge into the stored word
1 011 a5a5a5a5 f 2 00000000
1 011 000000ff 1 0 00000000
1 011 00bb0000 4 0 00000000
2 011 00000000 f 3 a5bba5ff
1 012 11223344 f 1 00000000
1 012 cafe0000 c 0 00000000
1 012 0000be00 2 0 00000000
2 012 00000000 f 5 cafebe44
# swaps return the old word
3 010 87654321 f 2 12345678
2 010 00000000 f 2 87654321
3 012 00000099 1 4 cafebe44
# back-to-back burst fills the queue
1 020 aaaa0001 f 0 00000000
1 021 aaaa0002 f 0 00000000
1 022 aaaa0003 f 0 00000000
1 3ff deadbeef f 0 00000000
2 020 00000000 f 0 aaaa0001
3 021 bbbb0002 f 0 aaaa0002
2 021 00000000 f 0 bbbb0002
2 022 00000000 f 0 aaaa0003
0 000 00000000 0 0 00000000
2 3ff 00000000 f 0 deadbeef
2 012 00000000 f 0 cafebe99
2 011 00000000 f 8 a5bba5ff
